//--- design/wstrb_fifo_pkg.sv
package wstrb_fifo_pkg;

    // buffer geometry
    localparam int fifo_depth  = 64;
    localparam int data_width  = 64;

    // derived widths
    localparam int adr_width   = $clog2(fifo_depth);
    // one extra bit so a full buffer can be counted
    localparam int count_width = $clog2(fifo_depth + 1);

    // one stored write-strobe word
    typedef logic [data_width-1:0]  fifo_data_t;

    // index of a RAM entry
    typedef logic [adr_width-1:0]   fifo_adr_t;

    // occupancy, 0 through fifo_depth
    typedef logic [count_width-1:0] fifo_count_t;

    // RAM write port, en doubles as the push event
    typedef struct packed {
        logic      en;
        fifo_adr_t adr;
    } ram_wr_t;

    // occupancy after one cycle; push and pop together leave it alone
    function automatic fifo_count_t count_next(
        input fifo_count_t count,
        input logic        up,
        input logic        down
    );
        fifo_count_t result;
        case ({up, down})
            2'b10:   result = count + fifo_count_t'(1);
            2'b01:   result = count - fifo_count_t'(1);
            default: result = count;
        endcase
        return result;
    endfunction

endpackage

//--- design/wstrb_fifo_write_ctl.sv
`timescale 1ns/100ps

module wstrb_fifo_write_ctl (
    input  logic                        clk,
    input  logic                        reset_,
    input  logic                        wr_req,
    input  wstrb_fifo_pkg::fifo_count_t wr_limit,
    input  logic                        pop,
    output logic                        wr_busy,
    output logic                        wr_empty,
    output wstrb_fifo_pkg::ram_wr_t     ram_wr
);
    import wstrb_fifo_pkg::*;

    // write-side view of occupancy
    fifo_count_t wr_count;
    fifo_count_t wr_count_next;

    // next free entry
    fifo_adr_t   wr_adr;
    fifo_adr_t   wr_adr_next;

    logic        push;
    logic        at_full;
    logic        limit_on;
    logic        at_limit;
    logic        wr_busy_next;
    logic        wr_empty_next;

    // accepted word, goes straight into the RAM this cycle
    assign push = wr_req && !wr_busy;

    // pop comes from the read side in the same cycle
    assign wr_count_next = count_next(wr_count, push, pop);

    // full check
    assign at_full = (wr_count_next == fifo_count_t'(fifo_depth));

    // zero limit means the full check alone decides
    assign limit_on = (wr_limit != '0);
    assign at_limit = limit_on && (wr_count_next >= wr_limit);

    // busy and empty are computed one cycle ahead and registered
    assign wr_busy_next  = at_full || at_limit;
    assign wr_empty_next = (wr_count_next == '0);

    always_ff @(posedge clk or negedge reset_) begin
        if (!reset_) begin
            wr_count <= '0;
            wr_busy  <= 1'b0;
            wr_empty <= 1'b1;
        end else begin
            // count only moves when exactly one side acts
            if (push ^ pop) begin
                wr_count <= wr_count_next;
            end
            wr_busy  <= wr_busy_next;
            wr_empty <= wr_empty_next;
        end
    end

    // wraps naturally at fifo_depth
    assign wr_adr_next = wr_adr + fifo_adr_t'(1);

    always_ff @(posedge clk or negedge reset_) begin
        if (!reset_) begin
            wr_adr <= '0;
        end else if (push) begin
            wr_adr <= wr_adr_next;
        end
    end

    // write port to the RAM and push event to the read side
    assign ram_wr = '{en: push, adr: wr_adr};

endmodule

//--- design/wstrb_fifo_flop_ram.sv
`timescale 1ns/100ps

module wstrb_fifo_flop_ram (
    input  logic                       clk,
    input  wstrb_fifo_pkg::ram_wr_t    ram_wr,
    input  wstrb_fifo_pkg::fifo_data_t wr_data,
    input  wstrb_fifo_pkg::fifo_adr_t  rd_adr,
    output wstrb_fifo_pkg::fifo_data_t rd_data
);
    import wstrb_fifo_pkg::*;

    // one flop row per entry
    fifo_data_t mem [fifo_depth];

    // decoded write enables, one per row
    logic [fifo_depth-1:0] row_we;

    always_comb begin
        row_we = '0;
        row_we[ram_wr.adr] = ram_wr.en;
    end

    // registered write, the word lands on the accepting edge
    always_ff @(posedge clk) begin
        for (int i = 0; i < fifo_depth; i++) begin
            if (row_we[i]) begin
                mem[i] <= wr_data;
            end
        end
    end

    // combinational read of the head entry
    assign rd_data = mem[rd_adr];

endmodule

//--- design/wstrb_fifo_read_ctl.sv
`timescale 1ns/100ps

module wstrb_fifo_read_ctl (
    input  logic                      clk,
    input  logic                      reset_,
    input  wstrb_fifo_pkg::ram_wr_t   ram_wr,
    input  logic                      rd_busy,
    output logic                      rd_req,
    output wstrb_fifo_pkg::fifo_adr_t rd_adr,
    output logic                      pop
);
    import wstrb_fifo_pkg::*;

    // read-side view of occupancy
    fifo_count_t rd_count;
    fifo_count_t rd_count_next;
    fifo_adr_t   rd_adr_next;

    logic        push;
    logic        rd_update;
    logic        rd_req_next;

    // write into the RAM is visible to this side right away
    assign push = ram_wr.en;

    // head word taken when valid and the receiver is ready
    assign pop = rd_req && !rd_busy;

    assign rd_count_next = count_next(rd_count, push, pop);
    assign rd_req_next   = (rd_count_next != '0);

    // nothing changes on this side without a push or a pop,
    // so rd_req holds steady under back-pressure
    assign rd_update = push || pop;

    always_ff @(posedge clk or negedge reset_) begin
        if (!reset_) begin
            rd_count <= '0;
            rd_req   <= 1'b0;
        end else if (rd_update) begin
            rd_count <= rd_count_next;
            rd_req   <= rd_req_next;
        end
    end

    // head moves on every pop
    assign rd_adr_next = rd_adr + fifo_adr_t'(1);

    always_ff @(posedge clk or negedge reset_) begin
        if (!reset_) begin
            rd_adr <= '0;
        end else if (pop) begin
            rd_adr <= rd_adr_next;
        end
    end

endmodule

//--- design/wstrb_fifo.sv
`timescale 1ns/100ps

module wstrb_fifo (
    input  logic                        clk,
    input  logic                        reset_,
    // write side
    input  logic                        wr_req,
    input  wstrb_fifo_pkg::fifo_data_t  wr_data,
    input  wstrb_fifo_pkg::fifo_count_t wr_limit,
    output logic                        wr_busy,
    output logic                        wr_empty,
    // read side
    input  logic                        rd_busy,
    output logic                        rd_req,
    output wstrb_fifo_pkg::fifo_data_t  rd_data
);
    import wstrb_fifo_pkg::*;

    // push event and write address, shared by the RAM and the read side
    ram_wr_t   ram_wr;

    // head entry address
    fifo_adr_t rd_adr;

    // pop event back to the write side
    logic      pop;

    // write side: occupancy, busy, empty, write address
    wstrb_fifo_write_ctl u_write_ctl (
        .clk      (clk),
        .reset_   (reset_),
        .wr_req   (wr_req),
        .wr_limit (wr_limit),
        .pop      (pop),
        .wr_busy  (wr_busy),
        .wr_empty (wr_empty),
        .ram_wr   (ram_wr)
    );

    // storage
    wstrb_fifo_flop_ram u_ram (
        .clk     (clk),
        .ram_wr  (ram_wr),
        .wr_data (wr_data),
        .rd_adr  (rd_adr),
        .rd_data (rd_data)
    );

    // read side: occupancy, head valid, read address
    wstrb_fifo_read_ctl u_read_ctl (
        .clk     (clk),
        .reset_  (reset_),
        .ram_wr  (ram_wr),
        .rd_busy (rd_busy),
        .rd_req  (rd_req),
        .rd_adr  (rd_adr),
        .pop     (pop)
    );

endmodule

//--- tests/wstrb_fifo_tb.sv
`timescale 1ns/100ps

module wstrb_fifo_tb;
    import wstrb_fifo_pkg::*;

    localparam int clk_period    = 40;
    localparam int reset_cycles  = 16;
    localparam int random_cycles = 3000;
    localparam int limit_runs    = 4;
    // writes offered after wr_busy rises, all of them must be dropped
    localparam int extra_cycles  = 10;
    localparam int planned_cycles = reset_cycles + random_cycles + fifo_depth
        + (1 + limit_runs) * (2 * fifo_depth + extra_cycles + 4);
    localparam int margin_cycles = 1000;

    logic        clk;
    logic        reset_;
    logic        wr_req;
    fifo_data_t  wr_data;
    fifo_count_t wr_limit;
    logic        wr_busy;
    logic        wr_empty;
    logic        rd_busy;
    logic        rd_req;
    fifo_data_t  rd_data;

    // reference model state
    fifo_data_t  model_q[$];
    fifo_count_t model_count;
    fifo_data_t  model_head;
    logic        push_seen;
    logic        pop_seen;
    logic        exp_busy;

    logic [31:0] rng_state = 32'h5620afcb;
    int          error_count = 0;
    int          push_total = 0;
    int          pop_total = 0;

    wstrb_fifo dut (
        .clk      (clk),
        .reset_   (reset_),
        .wr_req   (wr_req),
        .wr_data  (wr_data),
        .wr_limit (wr_limit),
        .wr_busy  (wr_busy),
        .wr_empty (wr_empty),
        .rd_busy  (rd_busy),
        .rd_req   (rd_req),
        .rd_data  (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function fifo_data_t new_word();
        fifo_data_t w;
        w[63:32] = next_random();
        w[31:0]  = next_random();
        return w;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        error_count++;
        $display("[ERROR] %0t %s: expected %0h, actual %0h", $time, name, expected, actual);
    endtask

    // events as seen at the ports
    assign push_seen = wr_req && !wr_busy;
    assign pop_seen  = rd_req && !rd_busy;
    assign exp_busy  = (model_count == fifo_count_t'(fifo_depth))
        || ((wr_limit != '0) && (model_count >= wr_limit));

    always @(posedge clk or negedge reset_) begin
        if (!reset_) begin
            model_q.delete();
            model_count <= '0;
            model_head  <= '0;
        end else begin
            // pop before push, so a one-entry queue hands over its head
            if (pop_seen && model_q.size() != 0) begin
                void'(model_q.pop_front());
                pop_total++;
            end
            if (push_seen) begin
                model_q.push_back(wr_data);
                push_total++;
            end
            model_count <= fifo_count_t'(model_q.size());
            model_head  <= (model_q.size() != 0) ? model_q[0] : '0;
        end
    end

    // bit order {wr_busy, rd_req, wr_empty}
    reset_state: assert property (@(posedge clk)
        !reset_ |-> (!wr_busy && !rd_req && wr_empty))
        else report_mismatch("reset_state", 64'(3'b001),
            64'({$sampled(wr_busy), $sampled(rd_req), $sampled(wr_empty)}));

    data_order: assert property (@(posedge clk) disable iff (!reset_)
        pop_seen |-> (rd_data == model_head))
        else report_mismatch("data_order", $sampled(model_head), $sampled(rd_data));

    busy_level: assert property (@(posedge clk) disable iff (!reset_)
        wr_busy == exp_busy)
        else report_mismatch("busy_level", 64'($sampled(exp_busy)), 64'($sampled(wr_busy)));

    empty_flag: assert property (@(posedge clk) disable iff (!reset_)
        wr_empty == (model_count == '0))
        else report_mismatch("empty_flag", 64'($sampled(model_count) == '0),
            64'($sampled(wr_empty)));

    head_valid: assert property (@(posedge clk) disable iff (!reset_)
        rd_req == (model_count != '0))
        else report_mismatch("head_valid", 64'($sampled(model_count) != '0),
            64'($sampled(rd_req)));

    // held head word under back-pressure
    head_stable: assert property (@(posedge clk) disable iff (!reset_)
        (rd_req && rd_busy) |=> $stable(rd_data))
        else report_mismatch("head_stable", $past(rd_data), $sampled(rd_data));

    task automatic drive_random_traffic(input int cycles);
        logic [31:0] r;
        for (int i = 0; i < cycles; i++) begin
            r = next_random();
            wr_req  = (r[3:0] < 4'd11);
            rd_busy = (r[7:4] < 4'd6);
            wr_data = new_word();
            @(negedge clk);
        end
    endtask

    task automatic drain_fifo(input string name);
        int waited;
        waited = 0;
        wr_req  = 1'b0;
        rd_busy = 1'b0;
        while (model_count != '0 && waited < 2 * fifo_depth) begin
            @(negedge clk);
            waited++;
        end
        if (model_count != '0) begin
            error_count++;
            $display("[ERROR] %s: buffer did not drain within %0d cycles", name, waited);
        end
    endtask

    // write continuously with the receiver stalled until wr_busy rises
    task automatic fill_until_busy(input string name);
        int waited;
        waited = 0;
        rd_busy = 1'b1;
        wr_req  = 1'b1;
        while (!wr_busy && waited < 2 * fifo_depth) begin
            wr_data = new_word();
            @(negedge clk);
            waited++;
        end
        if (!wr_busy) begin
            error_count++;
            $display("[ERROR] %s: wr_busy never rose after %0d writes", name, waited);
        end
        for (int i = 0; i < extra_cycles; i++) begin
            wr_data = new_word();
            @(negedge clk);
        end
        wr_req = 1'b0;
    endtask

    task automatic run_limit_test(input fifo_count_t limit);
        wr_limit = limit;
        @(negedge clk);
        fill_until_busy("write_limit");
        assert (model_count == limit)
            else report_mismatch("limit_count", 64'(limit), 64'(model_count));
        drain_fifo("write_limit");
        wr_limit = '0;
        @(negedge clk);
    endtask

    initial begin
        reset_   = 1'b1;
        wr_req   = 1'b0;
        wr_data  = '0;
        wr_limit = '0;
        rd_busy  = 1'b0;
        // a real falling edge on reset_ so the async reset fires
        #(clk_period / 4) reset_ = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset_ = 1'b1;
        @(negedge clk);

        drive_random_traffic(random_cycles);
        drain_fifo("data_order");

        fill_until_busy("full");
        assert (model_count == fifo_count_t'(fifo_depth))
            else report_mismatch("full_count", 64'(fifo_depth), 64'(model_count));
        drain_fifo("full");

        for (int i = 0; i < limit_runs; i++) begin
            run_limit_test(fifo_count_t'((next_random() % 32'd63) + 32'd1));
        end

        repeat (4) @(negedge clk);
        $display("pushes %0d, pops %0d, errors %0d", push_total, pop_total, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(clk_period * (planned_cycles + margin_cycles));
        $display("watchdog expired, run did not finish within %0d cycles",
            planned_cycles + margin_cycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- src.f
design/wstrb_fifo_pkg.sv
design/wstrb_fifo_write_ctl.sv
design/wstrb_fifo_flop_ram.sv
design/wstrb_fifo_read_ctl.sv
design/wstrb_fifo.sv
tests/wstrb_fifo_tb.sv

//--- Makefile
# Verilator build and run for the write-strobe FIFO testbench

SIM         ?= verilator
TOP         ?= wstrb_fifo_tb
FILELIST    ?= src.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
EXTRA_FLAGS ?=
SIM_FLAGS   ?= --binary --assert --timescale 1ns/100ps

PASS_MSG := Finished with no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) $(EXTRA_FLAGS)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation PASSED"; \
	else \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
